// File: rtl/l1d_pkg.sv
// shared widths and types for the L1 data cache
// physical addresses are 16 bits and accesses are 64-bit word aligned
// low 3 address bits are ignored by every block
package l1d_pkg;

  localparam int PADDR_BITS    = 16;
  localparam int WORD_BITS     = 64;
  localparam int LINE_WORDS    = 4;
  localparam int LINE_BITS     = WORD_BITS * LINE_WORDS;
  localparam int OFFSET_BITS   = $clog2(LINE_BITS / 8);
  localparam int INDEX_BITS    = 4;
  localparam int TAG_BITS      = PADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam int BLOCK_BITS    = PADDR_BITS - OFFSET_BITS;
  localparam int PTAG_BITS     = 10;
  localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);
  localparam int BYTE_BITS     = OFFSET_BITS - WORD_SEL_BITS;

  // set lookup view
  typedef struct packed {
    logic [TAG_BITS-1:0]      tag;
    logic [INDEX_BITS-1:0]    index;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic [BYTE_BITS-1:0]     byte_off;
  } l1d_array_view_t;

  // block match view
  typedef struct packed {
    logic [BLOCK_BITS-1:0]  block;
    logic [OFFSET_BITS-1:0] offset;
  } l1d_block_view_t;

  typedef union packed {
    l1d_array_view_t arr;
    l1d_block_view_t blk;
  } l1d_addr_u;

  // one request parked behind a pending block
  typedef struct packed {
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic                     we;
    logic [WORD_BITS-1:0]     data;
    logic [PTAG_BITS-1:0]     ptag;
  } mshr_req_t;

endpackage

// File: rtl/l1d_data_array.sv
// direct mapped storage of valid, dirty, tag and line per set
// lookup results are registered and hold until the next lookup strobe
// fill_we together with word_we drops the set without loading data
`timescale 1ns/10ps

module l1d_data_array
  import l1d_pkg::*;
(
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 lookup_en,
  input  logic                 word_we,
  input  logic                 fill_we,
  input  l1d_addr_u            addr,
  input  logic [WORD_BITS-1:0] word_data,
  input  logic [LINE_BITS-1:0] fill_line,
  output logic                 hit,
  output logic                 victim_dirty,
  output logic [WORD_BITS-1:0] rd_word,
  output l1d_addr_u            victim_addr,
  output logic [LINE_BITS-1:0] victim_line
);

  localparam int NUM_SETS = 1 << INDEX_BITS;

  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;
  logic [TAG_BITS-1:0]  tag_q  [NUM_SETS];
  logic [LINE_BITS-1:0] line_q [NUM_SETS];

  logic [INDEX_BITS-1:0] idx;
  logic                  invalidate;

  assign idx        = addr.arr.index;
  assign invalidate = fill_we && word_we;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q      <= '0;
      dirty_q      <= '0;
      hit          <= 1'b0;
      victim_dirty <= 1'b0;
    end else begin
      if (lookup_en) begin
        hit          <= valid_q[idx] && (tag_q[idx] == addr.arr.tag);
        victim_dirty <= valid_q[idx] && dirty_q[idx];
      end
      // a fill always leaves the set clean
      if (fill_we) begin
        valid_q[idx] <= !invalidate;
        dirty_q[idx] <= 1'b0;
      end else if (word_we) begin
        dirty_q[idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (lookup_en) begin
      rd_word     <= line_q[idx][addr.arr.word_sel * WORD_BITS +: WORD_BITS];
      victim_line <= line_q[idx];
      victim_addr <= {tag_q[idx], idx, {OFFSET_BITS{1'b0}}};
    end
    if (fill_we && !word_we) begin
      line_q[idx] <= fill_line;
      tag_q[idx]  <= addr.arr.tag;
    end else if (word_we && !fill_we) begin
      line_q[idx][addr.arr.word_sel * WORD_BITS +: WORD_BITS] <= word_data;
    end
  end

endmodule

// File: rtl/l1d_mshr_file.sv
// miss status holding registers, one pending block each with an in-order queue
// MSHR_COUNT and MSHR_DEPTH must be powers of two and at least 2
// push and pop are never issued in the same cycle by the controller
`timescale 1ns/10ps

module l1d_mshr_file
  import l1d_pkg::*;
#(
  parameter int MSHR_COUNT = 4,
  parameter int MSHR_DEPTH = 4
) (
  input  logic      clk_in,
  input  logic      rst_N_in,
  input  l1d_addr_u addr,
  input  logic      push_en,
  input  logic      pop_en,
  input  mshr_req_t push_req,
  input  l1d_addr_u retire_addr,
  output logic      match,
  output logic      match_full,
  output logic      any_free,
  output logic      set_conflict,
  output logic      push_primary,
  output logic      head_valid,
  output mshr_req_t head_req
);

  localparam int IDX_BITS = $clog2(MSHR_COUNT);
  localparam int PTR_BITS = $clog2(MSHR_DEPTH);
  localparam int CNT_BITS = $clog2(MSHR_DEPTH + 1);

  logic [MSHR_COUNT-1:0] valid_q;
  l1d_addr_u             blk_q   [MSHR_COUNT];
  logic [PTR_BITS-1:0]   head_q  [MSHR_COUNT];
  logic [CNT_BITS-1:0]   count_q [MSHR_COUNT];
  mshr_req_t             queue_q [MSHR_COUNT][MSHR_DEPTH];

  logic [MSHR_COUNT-1:0] hit_vec;
  logic [MSHR_COUNT-1:0] conf_vec;
  logic [MSHR_COUNT-1:0] ret_vec;
  logic [IDX_BITS-1:0]   match_idx;
  logic [IDX_BITS-1:0]   free_idx;
  logic [IDX_BITS-1:0]   ret_idx;
  logic [PTR_BITS-1:0]   tail_ptr;

  // scan from the top so the lowest free entry wins
  always_comb begin
    hit_vec   = '0;
    conf_vec  = '0;
    ret_vec   = '0;
    match_idx = '0;
    free_idx  = '0;
    ret_idx   = '0;
    for (int i = MSHR_COUNT - 1; i >= 0; i--) begin
      if (valid_q[i]) begin
        hit_vec[i]  = blk_q[i].blk.block == addr.blk.block;
        conf_vec[i] = (blk_q[i].arr.index == addr.arr.index) && !hit_vec[i];
        ret_vec[i]  = blk_q[i].blk.block == retire_addr.blk.block;
      end else begin
        free_idx = IDX_BITS'(i);
      end
      if (hit_vec[i])
        match_idx = IDX_BITS'(i);
      if (ret_vec[i])
        ret_idx = IDX_BITS'(i);
    end
  end

  assign match        = |hit_vec;
  assign match_full   = match && (count_q[match_idx] == CNT_BITS'(MSHR_DEPTH));
  assign any_free     = !(&valid_q);
  assign set_conflict = |conf_vec;
  assign push_primary = !match && any_free;
  assign head_valid   = |ret_vec;
  assign head_req     = queue_q[ret_idx][head_q[ret_idx]];
  assign tail_ptr     = head_q[match_idx] + PTR_BITS'(count_q[match_idx]);

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      for (int i = 0; i < MSHR_COUNT; i++) begin
        head_q[i]  <= '0;
        count_q[i] <= '0;
      end
    end else begin
      if (push_en && match && !match_full) begin
        count_q[match_idx] <= count_q[match_idx] + 1'b1;
      end else if (push_en && push_primary) begin
        valid_q[free_idx] <= 1'b1;
        head_q[free_idx]  <= '0;
        count_q[free_idx] <= CNT_BITS'(1);
      end
      // entry frees itself when its last request leaves
      if (pop_en && head_valid) begin
        head_q[ret_idx]  <= head_q[ret_idx] + 1'b1;
        count_q[ret_idx] <= count_q[ret_idx] - 1'b1;
        if (count_q[ret_idx] == CNT_BITS'(1))
          valid_q[ret_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (push_en && match && !match_full) begin
      queue_q[match_idx][tail_ptr] <= push_req;
    end else if (push_en && push_primary) begin
      queue_q[free_idx][0] <= push_req;
      blk_q[free_idx]      <= {addr.blk.block, {OFFSET_BITS{1'b0}}};
    end
  end

endmodule

// File: rtl/l1d_controller.sv
// request sequencing for the L1 data cache
// responses are one-cycle pulses with no LSU back-pressure
// a dirty victim is written back when the miss is found, before the fetch
`timescale 1ns/10ps

module l1d_controller
  import l1d_pkg::*;
(
  input  logic                  clk_in,
  input  logic                  rst_N_in,
  input  logic                  lsu_valid_in,
  input  logic                  lsu_we_in,
  input  logic [63:0]           lsu_addr_in,
  input  logic [WORD_BITS-1:0]  lsu_value_in,
  input  logic [PTAG_BITS-1:0]  lsu_tag_in,
  output logic                  lsu_ready_out,
  output logic                  lsu_valid_out,
  output logic                  lsu_write_complete_out,
  output logic [63:0]           lsu_addr_out,
  output logic [WORD_BITS-1:0]  lsu_value_out,
  output logic [PTAG_BITS-1:0]  lsu_tag_out,
  input  logic                  lc_ready_in,
  input  logic                  lc_valid_in,
  input  logic [PADDR_BITS-1:0] lc_addr_in,
  input  logic [LINE_BITS-1:0]  lc_value_in,
  output logic                  lc_valid_out,
  output logic                  lc_ready_out,
  output logic                  lc_we_out,
  output logic [PADDR_BITS-1:0] lc_addr_out,
  output logic [LINE_BITS-1:0]  lc_value_out,
  output logic                  lookup_en,
  output logic                  word_we,
  output logic                  fill_we,
  output l1d_addr_u             addr,
  output logic [WORD_BITS-1:0]  word_data,
  output logic [LINE_BITS-1:0]  fill_line,
  input  logic                  hit,
  input  logic                  victim_dirty,
  input  logic [WORD_BITS-1:0]  rd_word,
  input  l1d_addr_u             victim_addr,
  input  logic [LINE_BITS-1:0]  victim_line,
  output logic                  push_en,
  output logic                  pop_en,
  output mshr_req_t             push_req,
  input  logic                  match,
  input  logic                  match_full,
  input  logic                  any_free,
  input  logic                  set_conflict,
  input  logic                  push_primary,
  input  logic                  head_valid,
  input  mshr_req_t             head_req
);

  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_LOOKUP = 3'd1;
  localparam logic [2:0] S_CHECK  = 3'd2;
  localparam logic [2:0] S_WB     = 3'd3;
  localparam logic [2:0] S_FETCH  = 3'd4;
  localparam logic [2:0] S_FILL   = 3'd5;
  localparam logic [2:0] S_REPLAY = 3'd6;

  logic [2:0]            state_q, state_d;
  logic                  replay_q, rd_valid_q, wr_done_q;
  l1d_addr_u             req_addr_q;
  logic                  req_we_q;
  logic [WORD_BITS-1:0]  req_data_q;
  logic [PTAG_BITS-1:0]  req_tag_q;
  logic [BLOCK_BITS-1:0] refill_blk_q;

  // idle presents the incoming request so the MSHR flags can gate ready
  always_comb begin
    case (state_q)
      S_IDLE:   addr = lsu_addr_in[PADDR_BITS-1:0];
      S_FILL:   addr = lc_addr_in;
      S_REPLAY: addr = {refill_blk_q, head_req.word_sel, {BYTE_BITS{1'b0}}};
      default:  addr = req_addr_q;
    endcase
  end

  assign lsu_ready_out = (state_q == S_IDLE) && !lc_valid_in && !set_conflict &&
                         !match_full && (match || any_free);

  assign lookup_en = (state_q == S_LOOKUP) || pop_en;
  // writeback done, so the victim set is dropped through fill plus word write
  assign word_we   = ((state_q == S_CHECK) && hit && req_we_q) ||
                     ((state_q == S_WB) && lc_ready_in);
  assign fill_we   = (state_q == S_FILL) || ((state_q == S_WB) && lc_ready_in);
  assign word_data = req_data_q;
  assign fill_line = lc_value_in;

  assign push_en  = (state_q == S_CHECK) && !hit && !replay_q;
  assign pop_en   = (state_q == S_REPLAY) && head_valid;
  assign push_req = '{word_sel: req_addr_q.arr.word_sel, we: req_we_q,
                      data: req_data_q, ptag: req_tag_q};

  assign lc_valid_out = (state_q == S_WB) || (state_q == S_FETCH);
  assign lc_we_out    = (state_q == S_WB);
  assign lc_ready_out = (state_q == S_FILL);
  assign lc_addr_out  = (state_q == S_WB) ? victim_addr :
                        {req_addr_q.blk.block, {OFFSET_BITS{1'b0}}};
  assign lc_value_out = victim_line;

  // request registers stay put through the response cycle
  assign lsu_valid_out          = rd_valid_q;
  assign lsu_write_complete_out = wr_done_q;
  assign lsu_addr_out           = {{(64 - PADDR_BITS){1'b0}}, req_addr_q};
  assign lsu_value_out          = rd_word;
  assign lsu_tag_out            = req_tag_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (lc_valid_in)
          state_d = S_FILL;
        else if (lsu_valid_in && lsu_ready_out)
          state_d = S_LOOKUP;
      end
      S_LOOKUP: state_d = S_CHECK;
      S_CHECK: begin
        if (hit || replay_q)
          state_d = replay_q ? S_REPLAY : S_IDLE;
        else if (!push_primary)
          state_d = S_IDLE;
        else
          state_d = victim_dirty ? S_WB : S_FETCH;
      end
      S_WB:     state_d = lc_ready_in ? S_FETCH : S_WB;
      S_FETCH:  state_d = lc_ready_in ? S_IDLE : S_FETCH;
      S_FILL:   state_d = S_REPLAY;
      S_REPLAY: state_d = head_valid ? S_CHECK : S_IDLE;
      default:  state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q    <= S_IDLE;
      replay_q   <= 1'b0;
      rd_valid_q <= 1'b0;
      wr_done_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      rd_valid_q <= (state_q == S_CHECK) && hit && !req_we_q;
      wr_done_q  <= (state_q == S_CHECK) && hit && req_we_q;
      if (state_q == S_FILL)
        replay_q <= 1'b1;
      else if ((state_q == S_REPLAY) && !head_valid)
        replay_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if ((state_q == S_IDLE) && (state_d == S_LOOKUP)) begin
      req_addr_q <= addr;
      req_we_q   <= lsu_we_in;
      req_data_q <= lsu_value_in;
      req_tag_q  <= lsu_tag_in;
    end else if (pop_en) begin
      req_addr_q <= addr;
      req_we_q   <= head_req.we;
      req_data_q <= head_req.data;
      req_tag_q  <= head_req.ptag;
    end
    if (state_q == S_FILL)
      refill_blk_q <= lc_addr_in[PADDR_BITS-1:OFFSET_BITS];
  end

endmodule

// File: rtl/l1_data_cache.sv
// non-blocking, write-back, direct mapped L1 data cache
// LSU responses are single-cycle pulses that the LSU must take
// a request to a set with a pending block of another tag is held off
`timescale 1ns/10ps

module l1_data_cache
  import l1d_pkg::*;
#(
  parameter int MSHR_COUNT = 4,
  parameter int MSHR_DEPTH = 4
) (
  input  logic                  clk_in,
  input  logic                  rst_N_in,
  input  logic                  lsu_valid_in,
  input  logic                  lsu_we_in,
  input  logic [63:0]           lsu_addr_in,
  input  logic [WORD_BITS-1:0]  lsu_value_in,
  input  logic [PTAG_BITS-1:0]  lsu_tag_in,
  output logic                  lsu_ready_out,
  output logic                  lsu_valid_out,
  output logic                  lsu_write_complete_out,
  output logic [63:0]           lsu_addr_out,
  output logic [WORD_BITS-1:0]  lsu_value_out,
  output logic [PTAG_BITS-1:0]  lsu_tag_out,
  input  logic                  lc_ready_in,
  input  logic                  lc_valid_in,
  input  logic [PADDR_BITS-1:0] lc_addr_in,
  input  logic [LINE_BITS-1:0]  lc_value_in,
  output logic                  lc_valid_out,
  output logic                  lc_ready_out,
  output logic                  lc_we_out,
  output logic [PADDR_BITS-1:0] lc_addr_out,
  output logic [LINE_BITS-1:0]  lc_value_out
);

  logic                 lookup_en, word_we, fill_we;
  l1d_addr_u            addr, victim_addr;
  logic [WORD_BITS-1:0] word_data, rd_word;
  logic [LINE_BITS-1:0] fill_line, victim_line;
  logic                 hit, victim_dirty;
  logic                 push_en, pop_en;
  mshr_req_t            push_req, head_req;
  logic                 match, match_full, any_free, set_conflict, push_primary, head_valid;

  l1d_controller l1d_controller_inst (.*);

  l1d_data_array l1d_data_array_inst (.*);

  // during replay the controller address names the retiring block
  l1d_mshr_file #(
    .MSHR_COUNT(MSHR_COUNT),
    .MSHR_DEPTH(MSHR_DEPTH)
  ) l1d_mshr_file_inst (
    .retire_addr(addr),
    .*
  );

endmodule

// File: sim/l1_data_cache_assert.sv
// handshake properties of the L1 data cache top level
// fail_count is read back by the testbench at the end of the run
`timescale 1ns/10ps

module l1_data_cache_assert (
  input logic        clk_in,
  input logic        rst_N_in,
  input logic        lsu_valid_out,
  input logic        lsu_write_complete_out,
  input logic        lc_valid_out,
  input logic        lc_ready_in,
  input logic        lc_we_out,
  input logic [15:0] lc_addr_out,
  input logic        lc_ready_out,
  input logic        lc_valid_in
);

  int fail_count = 0;

  // one response kind per cycle
  resp_exclusive: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    !(lsu_valid_out && lsu_write_complete_out))
    else begin
      fail_count++;
      $error("read and write completion pulsed together");
    end

  lc_request_held: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (lc_valid_out && !lc_ready_in) |=>
      (lc_valid_out && $stable(lc_addr_out) && $stable(lc_we_out)))
    else begin
      fail_count++;
      $error("lower-cache request dropped or changed before lc_ready_in");
    end

  refill_taken_while_valid: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    lc_ready_out |-> lc_valid_in)
    else begin
      fail_count++;
      $error("lc_ready_out high without lc_valid_in");
    end

endmodule

bind l1_data_cache l1_data_cache_assert l1_data_cache_assert_inst (.*);

// File: sim/l1_data_cache_tb.sv
// testbench for the L1 data cache with a lower-cache model and a reference memory
// one request per table row, tag is row number plus one
// refills come 1 to 8 cycles after the fetch, or later while hold_left runs
`timescale 1ns/10ps

module l1_data_cache_tb import l1d_pkg::*; ();

  localparam int MSHR_COUNT = 4;
  localparam int MSHR_DEPTH = 4;
  localparam int ROWS       = 17;

  typedef struct packed {
    logic [3:0]  phase;
    logic [15:0] addr;
    logic        we;
    logic [63:0] val;
    logic        lat;
  } row_t;

  // phase, address, write, value, hit latency check
  localparam row_t TABLE [ROWS] = '{
    '{4'd1, 16'h0108, 1'b0, 64'h0, 1'b0},
    '{4'd2, 16'h0108, 1'b0, 64'h0, 1'b1},
    '{4'd3, 16'h0240, 1'b0, 64'h0, 1'b0},
    '{4'd3, 16'h0248, 1'b1, 64'h1111_2222_3333_4444, 1'b0},
    '{4'd3, 16'h0248, 1'b0, 64'h0, 1'b0},
    '{4'd3, 16'h0240, 1'b1, 64'h5555_6666_7777_8888, 1'b0},
    '{4'd3, 16'h0250, 1'b0, 64'h0, 1'b0},
    '{4'd3, 16'h0240, 1'b0, 64'h0, 1'b0},
    '{4'd4, 16'h0068, 1'b1, 64'hdead_beef_0bad_f00d, 1'b0},
    '{4'd5, 16'h0068, 1'b0, 64'h0, 1'b0},
    '{4'd6, 16'h0a60, 1'b0, 64'h0, 1'b0},
    '{4'd7, 16'h0068, 1'b0, 64'h0, 1'b0},
    '{4'd8, 16'h0540, 1'b0, 64'h0, 1'b0},
    '{4'd8, 16'h0560, 1'b0, 64'h0, 1'b0},
    '{4'd8, 16'h0580, 1'b0, 64'h0, 1'b0},
    '{4'd8, 16'h05a0, 1'b0, 64'h0, 1'b0},
    '{4'd8, 16'h05c0, 1'b0, 64'h0, 1'b0}
  };

  logic                  clk_in = 1'b0;
  logic                  rst_N_in;
  logic                  lsu_valid_in, lsu_we_in;
  logic [63:0]           lsu_addr_in;
  logic [WORD_BITS-1:0]  lsu_value_in;
  logic [PTAG_BITS-1:0]  lsu_tag_in;
  logic                  lsu_ready_out, lsu_valid_out, lsu_write_complete_out;
  logic [63:0]           lsu_addr_out;
  logic [WORD_BITS-1:0]  lsu_value_out;
  logic [PTAG_BITS-1:0]  lsu_tag_out;
  logic                  lc_ready_in, lc_valid_in;
  logic [PADDR_BITS-1:0] lc_addr_in;
  logic [LINE_BITS-1:0]  lc_value_in;
  logic                  lc_valid_out, lc_ready_out, lc_we_out;
  logic [PADDR_BITS-1:0] lc_addr_out;
  logic [LINE_BITS-1:0]  lc_value_out;

  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          outstanding = 0;
  bit          timed_out = 0;
  int          fetch_cnt = 0, wb_cnt = 0, fetch_base, wb_base;
  bit          last_was_wb = 0, fetch_after_wb = 0, saw_stall = 0, fill_taken = 0;
  int          hold_left = 0;
  int          cur_phase = 0;
  int          last_done = 0;
  logic [63:0] ref_mem [int];
  logic [63:0] lc_mem [int];
  logic [15:0] fetch_q [$];
  int          due_q [$];
  bit          pending [1024];
  bit          exp_we [1024];
  bit          exp_lat [1024];
  logic [63:0] exp_val [1024];
  logic [15:0] exp_addr [1024];
  int          acc_cyc [1024];

  l1_data_cache #(
    .MSHR_COUNT(MSHR_COUNT),
    .MSHR_DEPTH(MSHR_DEPTH)
  ) l1_data_cache_inst (.*);

  always #50 clk_in = ~clk_in;

  always @(posedge clk_in) cycle = cycle + 1;

  // contents of a word never written
  function automatic logic [63:0] init_word(input logic [15:0] a);
    return {~a, a ^ 16'h3c5a, a + 16'h1357, a};
  endfunction

  function automatic logic [63:0] ref_read(input logic [15:0] a);
    if (ref_mem.exists(int'(a)))
      return ref_mem[int'(a)];
    return init_word(a);
  endfunction

  function automatic logic [LINE_BITS-1:0] lc_line(input logic [15:0] blk);
    logic [LINE_BITS-1:0] line;
    logic [15:0]          a;
    for (int w = 0; w < LINE_WORDS; w++) begin
      a = blk + 16'(w * 8);
      line[w*WORD_BITS +: WORD_BITS] = lc_mem.exists(int'(a)) ? lc_mem[int'(a)] : init_word(a);
    end
    return line;
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // lower cache: accepts each transfer one cycle after it appears
  always @(negedge clk_in) begin
    if (!rst_N_in) begin
      lc_ready_in = 1'b0;
      lc_valid_in = 1'b0;
    end else begin
      if (lc_ready_in) begin
        lc_ready_in = 1'b0;
      end else if (lc_valid_out) begin
        lc_ready_in = 1'b1;
        if (lc_we_out) begin
          wb_cnt++;
          last_was_wb = 1'b1;
          for (int w = 0; w < LINE_WORDS; w++) begin
            check("writeback word", lc_value_out[w*WORD_BITS +: WORD_BITS],
                  ref_read(lc_addr_out + 16'(w * 8)));
            lc_mem[int'(lc_addr_out) + w * 8] = lc_value_out[w*WORD_BITS +: WORD_BITS];
          end
        end else begin
          fetch_cnt++;
          fetch_after_wb = last_was_wb;
          last_was_wb = 1'b0;
          fetch_q.push_back(lc_addr_out);
          due_q.push_back(cycle + 1 + int'($urandom_range(7)));
        end
      end
      if (hold_left > 0)
        hold_left--;
      // refill stays up through the edge that ends lc_ready_out
      if (lc_valid_in) begin
        if (fill_taken) begin
          lc_valid_in = 1'b0;
          fill_taken = 1'b0;
        end else if (lc_ready_out) begin
          fill_taken = 1'b1;
        end
      end else if (fetch_q.size() > 0 && cycle >= due_q[0] && hold_left == 0) begin
        lc_addr_in  = fetch_q.pop_front();
        void'(due_q.pop_front());
        lc_value_in = lc_line(lc_addr_in);
        lc_valid_in = 1'b1;
      end
    end
  end

  // scoreboard keyed by processor tag
  always @(negedge clk_in) begin
    int t;
    if (rst_N_in && (lsu_valid_out || lsu_write_complete_out)) begin
      t = int'(lsu_tag_out);
      if (!pending[t]) begin
        errors++;
        $display("unexpected or repeated response for tag %0d at %0t", t, $time);
      end else begin
        pending[t] = 1'b0;
        outstanding--;
        check("write flag", 64'(lsu_write_complete_out), 64'(exp_we[t]));
        if (!exp_we[t]) begin
          check("read data", lsu_value_out, exp_val[t]);
          check("read address", lsu_addr_out, {48'h0, exp_addr[t]});
        end
        // sampled three counts after the issue point, two cycles after acceptance
        if (exp_lat[t])
          check("hit latency", 64'(cycle - acc_cyc[t]), 64'd3);
        // requests queued on one block come back in request order
        if (cur_phase == 3) begin
          check("completion order", 64'(t > last_done), 64'd1);
          last_done = t;
        end
      end
    end
  end

  task automatic issue(input int r);
    int waited;
    bit done;
    int t;
    waited = 0;
    done   = 1'b0;
    t      = r + 1;
    lsu_valid_in = 1'b1;
    lsu_addr_in  = {48'h0, TABLE[r].addr};
    lsu_we_in    = TABLE[r].we;
    lsu_value_in = TABLE[r].val;
    lsu_tag_in   = PTAG_BITS'(t);
    while (!done && !timed_out) begin
      #1;
      if (lsu_ready_out) begin
        pending[t]  = 1'b1;
        exp_we[t]   = TABLE[r].we;
        exp_lat[t]  = TABLE[r].lat;
        exp_addr[t] = TABLE[r].addr;
        exp_val[t]  = ref_read(TABLE[r].addr);
        acc_cyc[t]  = cycle;
        outstanding++;
        if (TABLE[r].we)
          ref_mem[int'(TABLE[r].addr)] = TABLE[r].val;
        done = 1'b1;
      end else begin
        waited++;
        if (waited > 12 && !lc_valid_in)
          saw_stall = 1'b1;
        if (waited > 500) begin
          $display("timeout: row %0d was never accepted", r);
          timed_out = 1'b1;
        end
      end
      @(negedge clk_in);
    end
    lsu_valid_in = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (outstanding > 0 && !timed_out) begin
      @(negedge clk_in);
      waited++;
      if (waited > 3000) begin
        $display("timeout: %0d requests never completed", outstanding);
        timed_out = 1'b1;
      end
    end
    @(negedge clk_in);
  endtask

  task automatic phase_start(input int p);
    fetch_base     = fetch_cnt;
    wb_base        = wb_cnt;
    fetch_after_wb = 1'b0;
    saw_stall      = 1'b0;
    cur_phase      = p;
    last_done      = 0;
    if (p == 3)
      hold_left = 15;
    if (p == 8)
      hold_left = 40;
  endtask

  task automatic phase_check(input int p);
    if (p == 3)
      check("fetches for one block", 64'(fetch_cnt - fetch_base), 64'd1);
    if (p == 6) begin
      check("writebacks", 64'(wb_cnt - wb_base), 64'd1);
      check("writeback before fetch", 64'(fetch_after_wb), 64'd1);
    end
    if (p == 8)
      check("ready held low", 64'(saw_stall), 64'd1);
  endtask

  initial begin
    void'($urandom(32'h45ae_ebba));
    rst_N_in     = 1'b0;
    lsu_valid_in = 1'b0;
    lsu_we_in    = 1'b0;
    lsu_addr_in  = '0;
    lsu_value_in = '0;
    lsu_tag_in   = '0;
    lc_ready_in  = 1'b0;
    lc_valid_in  = 1'b0;
    lc_addr_in   = '0;
    lc_value_in  = '0;
    repeat (2) @(negedge clk_in);
    rst_N_in = 1'b1;
    @(negedge clk_in);
    check("lsu_valid_out after reset", 64'(lsu_valid_out), 64'd0);
    check("lsu_write_complete_out after reset", 64'(lsu_write_complete_out), 64'd0);
    check("lc_valid_out after reset", 64'(lc_valid_out), 64'd0);
    check("lc_ready_out after reset", 64'(lc_ready_out), 64'd0);
    check("lsu_ready_out after reset", 64'(lsu_ready_out), 64'd1);
    for (int r = 0; r < ROWS; r++) begin
      if (!timed_out) begin
        if (r == 0 || TABLE[r].phase != TABLE[r-1].phase) begin
          if (r != 0) begin
            drain();
            phase_check(TABLE[r-1].phase);
          end
          phase_start(TABLE[r].phase);
        end
        issue(r);
      end
    end
    drain();
    if (!timed_out)
      phase_check(TABLE[ROWS-1].phase);
    errors += l1_data_cache_inst.l1_data_cache_assert_inst.fail_count;
    $display("checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: verilog.f
rtl/l1d_pkg.sv
rtl/l1d_data_array.sv
rtl/l1d_mshr_file.sv
rtl/l1d_controller.sv
rtl/l1_data_cache.sv
sim/l1_data_cache_assert.sv
sim/l1_data_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= l1_data_cache_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= *** PASSED ***

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
